// File: routePkg.sv
package routePkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////////////////////////////////////////

	// One data item
	typedef logic [3:0] nibble_t;

	// Lane number, room for four lanes
	typedef logic [1:0] laneIdx_t;

	// How items are spread over the lanes
	typedef enum logic {
		modeFixed  = 1'b0,
		modeRotate = 1'b1
	} routeMode_t;

	////////////////////////////////////////////////////////////////////////////
	// Dispatcher to lane transfer
	////////////////////////////////////////////////////////////////////////////

	// Valid high means push this cycle
	typedef struct packed {
		nibble_t data;
		logic    valid;
	} laneItem_t;

endpackage

// File: regPkg.sv
package regPkg;

	import routePkg::*;

	// AXI4-Lite field widths
	typedef logic [3:0]  axilAddr_t;
	typedef logic [31:0] axilData_t;
	typedef logic [1:0]  axilResp_t;

	// Register map
	parameter axilAddr_t ADDR_MODE = 4'h0;
	parameter axilAddr_t ADDR_KEYS = 4'h4;

	// Response codes in use
	parameter axilResp_t RESP_OKAY   = 2'b00;
	parameter axilResp_t RESP_SLVERR = 2'b10;

	// Master side, AW W B AR R
	typedef struct packed {
		logic      awValid;
		axilAddr_t awAddr;
		logic      wValid;
		axilData_t wData;
		logic      bReady;
		logic      arValid;
		axilAddr_t arAddr;
		logic      rReady;
	} axilReq_t;

	// Slave side
	typedef struct packed {
		logic      awReady;
		logic      wReady;
		logic      bValid;
		axilResp_t bResp;
		logic      arReady;
		logic      rValid;
		axilData_t rData;
		axilResp_t rResp;
	} axilRsp_t;

	// Routing configuration, lane 0 key in keys[0]
	typedef struct packed {
		routeMode_t    mode;
		laneIdx_t      fixedLane;
		nibble_t [3:0] keys;
	} routeCfg_t;

endpackage

// File: fifoSync.sv
module fifoSync import routePkg::*; #(
	parameter int DEPTH = 8
) (
	input  logic    inClock,
	input  logic    rstN,
	input  logic    push,
	input  nibble_t pushData,
	input  logic    pop,
	output nibble_t headData,
	output logic    empty,
	output logic    full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	nibble_t          mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic             doPush;
	logic             doPop;

	// Circular pointer step
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Flags from the item count
	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	// Push while full is ignored, same for pop while empty
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	// Head straight from storage
	assign headData = mem[rdPtr];

	always_ff @(posedge inClock) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge inClock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// Simultaneous push and pop keeps the count
			count <= count + CNT_W'(doPush) - CNT_W'(doPop);
		end
	end

	// Producer side must watch full
	pushWhileFull: assert property (@(posedge inClock) disable iff (!rstN)
		!(push && full))
		else $error("fifoSync push while full, item lost");

	// Consumer side must watch empty
	popWhileEmpty: assert property (@(posedge inClock) disable iff (!rstN)
		!(pop && empty))
		else $error("fifoSync pop while empty");

endmodule

// File: regFile.sv
module regFile import routePkg::*, regPkg::*; (
	input  logic      inClock,
	input  logic      rstN,
	input  axilReq_t  axilReq,
	output axilRsp_t  axilRsp,
	output routeCfg_t cfg
);

	typedef enum logic {
		wrIdle,
		wrResp
	} wrState_t;

	typedef enum logic {
		rdIdle,
		rdResp
	} rdState_t;

	wrState_t  wrState;
	rdState_t  rdState;
	axilResp_t bResp;
	axilResp_t rResp;
	axilData_t rData;
	logic      wrFire;
	logic      rdFire;

	// AW and W accepted together
	assign wrFire = (wrState == wrIdle) && axilReq.awValid && axilReq.wValid;
	assign rdFire = (rdState == rdIdle) && axilReq.arValid;

	always_comb begin
		axilRsp.awReady = wrFire;
		axilRsp.wReady  = wrFire;
		axilRsp.bValid  = (wrState == wrResp);
		axilRsp.bResp   = bResp;
		axilRsp.arReady = (rdState == rdIdle);
		axilRsp.rValid  = (rdState == rdResp);
		axilRsp.rData   = rData;
		axilRsp.rResp   = rResp;
	end

	////////////////////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge inClock or negedge rstN) begin
		if (!rstN) begin
			wrState <= wrIdle;
			bResp   <= RESP_OKAY;
			// Fixed mode on lane 0 with all keys clear
			cfg     <= '{mode: modeFixed, fixedLane: '0, keys: '0};
		end else begin
			case (wrState)
				wrIdle: begin
					if (wrFire) begin
						wrState <= wrResp;
						bResp   <= RESP_OKAY;
						case (axilReq.awAddr)
							ADDR_MODE: begin
								cfg.mode      <= routeMode_t'(axilReq.wData[0]);
								cfg.fixedLane <= axilReq.wData[2:1];
							end
							ADDR_KEYS: begin
								cfg.keys <= axilReq.wData[15:0];
							end
							// Unmapped address leaves the config alone
							default: begin
								bResp <= RESP_SLVERR;
							end
						endcase
					end
				end
				wrResp: begin
					if (axilReq.bReady) begin
						wrState <= wrIdle;
					end
				end
				default: begin
					wrState <= wrIdle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge inClock or negedge rstN) begin
		if (!rstN) begin
			rdState <= rdIdle;
			rData   <= '0;
			rResp   <= RESP_OKAY;
		end else begin
			case (rdState)
				rdIdle: begin
					if (rdFire) begin
						rdState <= rdResp;
						rResp   <= RESP_OKAY;
						case (axilReq.arAddr)
							ADDR_MODE: rData <= axilData_t'({cfg.fixedLane, cfg.mode});
							ADDR_KEYS: rData <= axilData_t'(cfg.keys);
							default: begin
								rData <= '0;
								rResp <= RESP_SLVERR;
							end
						endcase
					end
				end
				rdResp: begin
					if (axilReq.rReady) begin
						rdState <= rdIdle;
					end
				end
				default: begin
					rdState <= rdIdle;
				end
			endcase
		end
	end

	// Response held until the master takes it
	bHeld: assert property (@(posedge inClock) disable iff (!rstN)
		axilRsp.bValid && !axilReq.bReady |=> axilRsp.bValid);

	rHeld: assert property (@(posedge inClock) disable iff (!rstN)
		axilRsp.rValid && !axilReq.rReady |=> axilRsp.rValid && $stable(axilRsp.rData));

endmodule

// File: laneDemux.sv
module laneDemux import routePkg::*, regPkg::*; #(
	parameter int LANES = 4
) (
	input  logic                  inClock,
	input  logic                  rstN,
	input  routeCfg_t             cfg,
	input  nibble_t               srcData,
	input  logic                  srcEmpty,
	output logic                  srcPop,
	input  logic [LANES-1:0]      laneFull,
	output laneItem_t [LANES-1:0] laneIn
);

	laneIdx_t         rotPtr;
	laneIdx_t         target;
	logic             xfer;
	logic [LANES-1:0] pushVec;

	// Target lane from the mode
	assign target = (cfg.mode == modeFixed) ? cfg.fixedLane : rotPtr;

	// Move when there is an item and room in the target
	assign xfer   = !srcEmpty && !laneFull[target];
	assign srcPop = xfer;

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			pushVec[i]      = xfer && (target == laneIdx_t'(i));
			laneIn[i].data  = srcData;
			laneIn[i].valid = pushVec[i];
		end
	end

	// Rotation pointer, steps only on a transfer
	always_ff @(posedge inClock or negedge rstN) begin
		if (!rstN) begin
			rotPtr <= '0;
		end else if (xfer && (cfg.mode == modeRotate)) begin
			rotPtr <= (rotPtr == laneIdx_t'(LANES - 1)) ? '0 : rotPtr + 1'b1;
		end
	end

	onePush: assert property (@(posedge inClock) disable iff (!rstN)
		$onehot0(pushVec));

	// Fixed lane must exist
	fixedInRange: assert property (@(posedge inClock) disable iff (!rstN)
		cfg.mode == modeFixed |-> int'(cfg.fixedLane) < LANES);

endmodule

// File: laneStage.sv
module laneStage import routePkg::*; #(
	parameter int LANE_DEPTH = 2
) (
	input  logic      inClock,
	input  logic      rstN,
	input  nibble_t   key,
	input  laneItem_t laneIn,
	output logic      laneFull,
	input  logic      pop,
	output nibble_t   outData,
	output logic      outValid
);

	nibble_t headData;
	logic    empty;

	// Lane buffer, decouples dispatcher from collector
	fifoSync #(
		.DEPTH(LANE_DEPTH)
	) uLaneFifo (
		.inClock  (inClock),
		.rstN     (rstN),
		.push     (laneIn.valid),
		.pushData (laneIn.data),
		.pop      (pop),
		.headData (headData),
		.empty    (empty),
		.full     (laneFull)
	);

	// Key applied on the way out
	assign outData  = headData ^ key;
	assign outValid = !empty;

	// Item into an empty lane is visible next cycle
	pushShows: assert property (@(posedge inClock) disable iff (!rstN)
		laneIn.valid && empty |=> outValid);

endmodule

// File: laneMux.sv
module laneMux import routePkg::*, regPkg::*; #(
	parameter int LANES = 4
) (
	input  logic                inClock,
	input  logic                rstN,
	input  routeCfg_t           cfg,
	input  nibble_t [LANES-1:0] laneData,
	input  logic [LANES-1:0]    laneValid,
	output logic [LANES-1:0]    lanePop,
	output logic                dstPush,
	output nibble_t             dstData,
	input  logic                dstFull
);

	laneIdx_t rotPtr;
	laneIdx_t source;
	logic     xfer;

	// Same lane order as the dispatcher
	assign source = (cfg.mode == modeFixed) ? cfg.fixedLane : rotPtr;

	// Wait on the source lane, never skip it
	assign xfer    = laneValid[source] && !dstFull;
	assign dstPush = xfer;
	assign dstData = laneData[source];

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lanePop[i] = xfer && (source == laneIdx_t'(i));
		end
	end

	// Mirror of the dispatcher pointer
	always_ff @(posedge inClock or negedge rstN) begin
		if (!rstN) begin
			rotPtr <= '0;
		end else if (xfer && (cfg.mode == modeRotate)) begin
			rotPtr <= (rotPtr == laneIdx_t'(LANES - 1)) ? '0 : rotPtr + 1'b1;
		end
	end

	onePop: assert property (@(posedge inClock) disable iff (!rstN)
		$onehot0(lanePop));

	// Waiting lane heads stay put until collected
	headsHeld: assert property (@(posedge inClock) disable iff (!rstN)
		(laneValid & ~lanePop) != '0
		|=> ($past(laneValid & ~lanePop) & ~laneValid) == '0);

endmodule

// File: routeTop.sv
module routeTop import routePkg::*, regPkg::*; #(
	parameter int LANES      = 4,
	parameter int IN_DEPTH   = 8,
	parameter int OUT_DEPTH  = 8,
	parameter int LANE_DEPTH = 2
) (
	input  logic     inClock,
	input  logic     rstN,
	input  nibble_t  inData,
	input  logic     inWriteEnable,
	output logic     inFull,
	output nibble_t  outData,
	output logic     outValid,
	input  logic     outReadEnable,
	input  axilReq_t axilReq,
	output axilRsp_t axilRsp
);

	routeCfg_t             cfg;
	nibble_t               srcData;
	logic                  srcEmpty;
	logic                  srcPop;
	laneItem_t [LANES-1:0] laneIn;
	logic [LANES-1:0]      laneFull;
	nibble_t [LANES-1:0]   laneData;
	logic [LANES-1:0]      laneValid;
	logic [LANES-1:0]      lanePop;
	logic                  dstPush;
	nibble_t               dstData;
	logic                  dstFull;
	logic                  outEmpty;
	logic                  outPop;

	regFile uRegFile (
		.inClock (inClock),
		.rstN    (rstN),
		.axilReq (axilReq),
		.axilRsp (axilRsp),
		.cfg     (cfg)
	);

	////////////////////////////////////////////////////////////////////////////
	// Input FIFO and dispatcher
	////////////////////////////////////////////////////////////////////////////

	fifoSync #(
		.DEPTH(IN_DEPTH)
	) uInFifo (
		.inClock  (inClock),
		.rstN     (rstN),
		.push     (inWriteEnable),
		.pushData (inData),
		.pop      (srcPop),
		.headData (srcData),
		.empty    (srcEmpty),
		.full     (inFull)
	);

	laneDemux #(
		.LANES(LANES)
	) uDemux (
		.inClock  (inClock),
		.rstN     (rstN),
		.cfg      (cfg),
		.srcData  (srcData),
		.srcEmpty (srcEmpty),
		.srcPop   (srcPop),
		.laneFull (laneFull),
		.laneIn   (laneIn)
	);

	// One stage per lane, each with its own key
	for (genvar i = 0; i < LANES; i++) begin : gLane
		laneStage #(
			.LANE_DEPTH(LANE_DEPTH)
		) uLane (
			.inClock  (inClock),
			.rstN     (rstN),
			.key      (cfg.keys[i]),
			.laneIn   (laneIn[i]),
			.laneFull (laneFull[i]),
			.pop      (lanePop[i]),
			.outData  (laneData[i]),
			.outValid (laneValid[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Collector and output FIFO
	////////////////////////////////////////////////////////////////////////////

	laneMux #(
		.LANES(LANES)
	) uMux (
		.inClock   (inClock),
		.rstN      (rstN),
		.cfg       (cfg),
		.laneData  (laneData),
		.laneValid (laneValid),
		.lanePop   (lanePop),
		.dstPush   (dstPush),
		.dstData   (dstData),
		.dstFull   (dstFull)
	);

	// Read enable only counts while an item is shown
	assign outPop   = outReadEnable && outValid;
	assign outValid = !outEmpty;

	fifoSync #(
		.DEPTH(OUT_DEPTH)
	) uOutFifo (
		.inClock  (inClock),
		.rstN     (rstN),
		.push     (dstPush),
		.pushData (dstData),
		.pop      (outPop),
		.headData (outData),
		.empty    (outEmpty),
		.full     (dstFull)
	);

endmodule

// File: tbChecker.sv
module tbChecker import routePkg::*, regPkg::*; #(
	parameter int LANES = 4
) (
	input  logic      inClock,
	input  logic      rstN,
	input  routeCfg_t cfg,
	input  nibble_t   inData,
	input  logic      inWriteEnable,
	input  logic      inFull,
	input  nibble_t   outData,
	input  logic      outValid,
	input  logic      outReadEnable,
	output int        errCount,
	output int        readCount,
	output int        pending
);

	nibble_t expQ [$];
	nibble_t expected;
	int      inIndex = 0;
	int      errors  = 0;
	int      reads   = 0;
	int      queued  = 0;

	assign errCount  = errors;
	assign readCount = reads;
	assign pending   = queued;

	// Lane from the mode, index counted since the last reset
	function automatic nibble_t keyedItem(input nibble_t data, input int index);
		laneIdx_t lane;
		if (cfg.mode == modeRotate) begin
			lane = laneIdx_t'(index % LANES);
		end else begin
			lane = cfg.fixedLane;
		end
		return data ^ cfg.keys[lane];
	endfunction

	// Falling edge sees the values that the next rising edge acts on
	always @(negedge inClock or negedge rstN) begin
		if (!rstN) begin
			if (expQ.size() != 0) begin
				$display("%0t: reset with %0d items still expected, items were lost",
					$time, expQ.size());
				errors++;
			end
			expQ.delete();
			inIndex = 0;
		end else begin
			// Read completes on the coming rising edge
			if (outValid && outReadEnable) begin
				if (expQ.size() == 0) begin
					$display("%0t: item %h came out with nothing expected", $time, outData);
					errors++;
				end else begin
					expected = expQ.pop_front();
					reads++;
					if (outData !== expected) begin
						$display("Fail %0t: output item %0d expected %h, got %h",
							$time, reads, expected, outData);
						errors++;
					end
				end
			end
			// Accepted write, queued with its lane key
			if (inWriteEnable && !inFull) begin
				expQ.push_back(keyedItem(inData, inIndex));
				inIndex++;
			end
		end
		queued = expQ.size();
	end

endmodule

// File: tbRoute.sv
module tbRoute import routePkg::*, regPkg::*; ();

	localparam int LANES     = 4;
	localparam int MAX_TESTS = 8;
	localparam int MAX_ITEMS = 256;

	logic      inClock = 1'b0;
	logic      rstN    = 1'b0;
	nibble_t   inData;
	logic      inWriteEnable;
	logic      inFull;
	nibble_t   outData;
	logic      outValid;
	logic      outReadEnable;
	axilReq_t  axilReq;
	axilRsp_t  axilRsp;
	routeCfg_t cfgShadow;

	// Test table from the data file
	int        nTests;
	int        modeArr  [MAX_TESTS];
	int        laneArr  [MAX_TESTS];
	int        keysArr  [MAX_TESTS];
	int        countArr [MAX_TESTS];
	int        stallArr [MAX_TESTS];
	int        baseArr  [MAX_TESTS];
	nibble_t   items    [MAX_ITEMS];
	int        totalItems;

	int        tbErrors    = 0;
	int        dataErrors;
	int        readCount;
	int        pending;
	int        watchCycles = 0;
	integer    seed        = 32'h42fe;

	routeTop #(
		.LANES      (LANES),
		.IN_DEPTH   (8),
		.OUT_DEPTH  (8),
		.LANE_DEPTH (2)
	) i_dut (
		.inClock       (inClock),
		.rstN          (rstN),
		.inData        (inData),
		.inWriteEnable (inWriteEnable),
		.inFull        (inFull),
		.outData       (outData),
		.outValid      (outValid),
		.outReadEnable (outReadEnable),
		.axilReq       (axilReq),
		.axilRsp       (axilRsp)
	);

	tbChecker #(
		.LANES(LANES)
	) uChecker (
		.inClock       (inClock),
		.rstN          (rstN),
		.cfg           (cfgShadow),
		.inData        (inData),
		.inWriteEnable (inWriteEnable),
		.inFull        (inFull),
		.outData       (outData),
		.outValid      (outValid),
		.outReadEnable (outReadEnable),
		.errCount      (dataErrors),
		.readCount     (readCount),
		.pending       (pending)
	);

	always #4 inClock = ~inClock;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input axilData_t got, input axilData_t want);
		if (got !== want) begin
			$display("Fail %0t: %s expected %h, got %h", $time, what, want, got);
			tbErrors++;
		end
	endtask

	// Four lines per test after two comment lines and the test count
	task automatic loadTests(output logic ok);
		int    fd;
		int    n;
		int    a;
		int    b;
		string line;
		ok         = 1'b0;
		totalItems = 0;
		fd         = $fopen("routeInput.txt", "r");
		if (fd != 0) begin
			n  = $fgets(line, fd);
			n  = $fgets(line, fd);
			n  = $fscanf(fd, "%d", nTests);
			ok = (n == 1) && (nTests > 0) && (nTests <= MAX_TESTS);
			for (int t = 0; ok && t < nTests; t++) begin
				n          = $fscanf(fd, "%d %d", a, b);
				ok         = (n == 2);
				modeArr[t] = a;
				laneArr[t] = b;
				n          = $fscanf(fd, "%h", a);
				ok         = ok && (n == 1);
				keysArr[t] = a;
				n          = $fscanf(fd, "%d", a);
				ok         = ok && (n == 1) && (totalItems + a <= MAX_ITEMS);
				countArr[t] = a;
				baseArr[t]  = totalItems;
				for (int i = 0; ok && i < countArr[t]; i++) begin
					n                     = $fscanf(fd, "%h", a);
					ok                    = (n == 1);
					items[totalItems + i] = nibble_t'(a);
				end
				totalItems += countArr[t];
				n           = $fscanf(fd, "%d", a);
				ok          = ok && (n == 1);
				stallArr[t] = a;
			end
			$fclose(fd);
		end
	endtask

	task automatic applyReset();
		@(posedge inClock);
		#1;
		rstN          = 1'b0;
		inWriteEnable = 1'b0;
		outReadEnable = 1'b0;
		repeat (3) @(posedge inClock);
		#1;
		rstN = 1'b1;
	endtask

	// Ready and valid sampled on the falling edge before the rising edge handshake
	task automatic writeReg(input axilAddr_t addr, input axilData_t data,
		output axilResp_t resp);
		@(posedge inClock);
		#1;
		axilReq.awValid = 1'b1;
		axilReq.awAddr  = addr;
		axilReq.wValid  = 1'b1;
		axilReq.wData   = data;
		axilReq.bReady  = 1'b1;
		@(negedge inClock);
		while (!(axilRsp.awReady && axilRsp.wReady)) @(negedge inClock);
		@(posedge inClock);
		#1;
		axilReq.awValid = 1'b0;
		axilReq.wValid  = 1'b0;
		@(negedge inClock);
		while (!axilRsp.bValid) @(negedge inClock);
		resp = axilRsp.bResp;
		@(posedge inClock);
		#1;
		axilReq.bReady = 1'b0;
	endtask

	task automatic readReg(input axilAddr_t addr, output axilData_t data,
		output axilResp_t resp);
		@(posedge inClock);
		#1;
		axilReq.arValid = 1'b1;
		axilReq.arAddr  = addr;
		axilReq.rReady  = 1'b1;
		@(negedge inClock);
		while (!axilRsp.arReady) @(negedge inClock);
		@(posedge inClock);
		#1;
		axilReq.arValid = 1'b0;
		@(negedge inClock);
		while (!axilRsp.rValid) @(negedge inClock);
		data = axilRsp.rData;
		resp = axilRsp.rResp;
		@(posedge inClock);
		#1;
		axilReq.rReady = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One test with reset, configuration and the item stream
	////////////////////////////////////////////////////////////////////////////

	task automatic runTest(input int t);
		axilResp_t resp;
		axilData_t data;
		axilData_t modeWord;
		int        idx;
		int        roll;
		logic      holdMode;
		logic      sawFull;
		logic      finished;
		modeWord = axilData_t'(laneArr[t] * 2 + modeArr[t]);
		applyReset();
		checkValue("outValid after reset", axilData_t'(outValid), '0);
		checkValue("inFull after reset", axilData_t'(inFull), '0);
		readReg(ADDR_MODE, data, resp);
		checkValue("mode register after reset", data, '0);
		checkValue("mode read response", axilData_t'(resp), axilData_t'(RESP_OKAY));
		readReg(ADDR_KEYS, data, resp);
		checkValue("keys register after reset", data, '0);

		writeReg(ADDR_MODE, modeWord, resp);
		checkValue("mode write response", axilData_t'(resp), axilData_t'(RESP_OKAY));
		writeReg(ADDR_KEYS, axilData_t'(keysArr[t][15:0]), resp);
		checkValue("keys write response", axilData_t'(resp), axilData_t'(RESP_OKAY));
		cfgShadow.mode      = routeMode_t'(modeArr[t][0]);
		cfgShadow.fixedLane = laneIdx_t'(laneArr[t]);
		cfgShadow.keys      = keysArr[t][15:0];

		// Unmapped address gets SLVERR and leaves the config alone
		writeReg(4'hC, 32'hffff_ffff, resp);
		checkValue("unmapped write response", axilData_t'(resp), axilData_t'(RESP_SLVERR));
		readReg(ADDR_MODE, data, resp);
		checkValue("mode read-back", data, modeWord);
		readReg(ADDR_KEYS, data, resp);
		checkValue("keys read-back", data, axilData_t'(keysArr[t][15:0]));

		idx      = 0;
		holdMode = (stallArr[t] >= 100);
		sawFull  = 1'b0;
		finished = 1'b0;
		while (!finished) begin
			@(posedge inClock);
			#1;
			sawFull = sawFull || inFull;
			// No write offered while full
			if (idx < countArr[t] && !inFull) begin
				inData        = items[baseArr[t] + idx];
				inWriteEnable = 1'b1;
				idx++;
			end else begin
				inWriteEnable = 1'b0;
			end
			roll = int'($unsigned($random(seed)) % 100);
			if (holdMode) begin
				// Reads held until back-pressure reaches the write side
				outReadEnable = sawFull || (idx >= countArr[t]);
			end else begin
				outReadEnable = (roll >= stallArr[t]);
			end
			finished = (idx >= countArr[t]) && !inWriteEnable && (pending == 0);
		end
		outReadEnable = 1'b0;
		checkValue("outValid after draining", axilData_t'(outValid), '0);
		if (holdMode && !sawFull) begin
			$display("Test %0d: inFull never rose while reads were held", t);
			tbErrors++;
		end
	endtask

	initial begin
		logic ok;
		inData        = '0;
		inWriteEnable = 1'b0;
		outReadEnable = 1'b0;
		axilReq       = '0;
		cfgShadow     = '0;
		loadTests(ok);
		if (!ok) begin
			$display("Could not read the test table from routeInput.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			watchCycles = totalItems * 40 + 200;
			for (int t = 0; t < nTests; t++) begin
				runTest(t);
			end
			$display("Errors: %0d testbench, %0d data, %0d items read",
				tbErrors, dataErrors, readCount);
			if (tbErrors + dataErrors == 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

	// Limit scales with the item count of the whole table
	initial begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge inClock);
		$display("Timeout: run did not finish within %0d cycles", watchCycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: routeInput.txt
# mode (0 fixed, 1 rotate) and fixed lane | keys in hex, lane 0 in the low nibble
# item count then hex items | read stall percent, 100 holds reads until inFull
5
0 2
0a00
10 3 7 0 f 9 1 c 5 a 6
0
1 0
7c31
12 0 1 2 3 4 5 6 7 8 9 a b
0
1 0
5e9b
30 e 2 9 4 b 0 7 d 3 8 1 f 6 a c 5 2 e 0 9 7 b 4 d 8 3 f 1 a 6
100
1 0
d2f6
24 5 c 1 8 f 3 a 0 6 d 2 9 e 4 b 7 1 5 c 8 0 f 3 a
40
0 1
0040
16 f e d c b a 9 8 7 6 5 4 3 2 1 0
25

// File: files.f
routePkg.sv
regPkg.sv
fifoSync.sv
regFile.sv
laneDemux.sv
laneStage.sv
laneMux.sv
routeTop.sv
tbChecker.sv
tbRoute.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbRoute
FILELIST = files.f
BUILD    = obj_dir
PASS     = TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)
